// ==== src.f ====
common/lsu_pkg.sv
common/lsu_req_if.sv
lsu/lsu_request.sv
lsu/lsu_txn_tracker.sv
lsu/lsu_rdata_align.sv
verilog/lsu_top.sv
tests/tb_lsu_mem.sv
tests/tb_lsu.sv

// ==== Makefile ====
# Verilator build and run of the load-store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
FILELIST  ?= src.f

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only when the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_lsu.sv ====
/*
 * Testbench of the load-store unit
 * Clock, reset, LFSR stimulus, golden byte model, checks, timeout, report
 */

`default_nettype none

module tb_lsu;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH        = 2;
  localparam int N_ACC        = 24;
  localparam int KIND_ALIGNED = 0;
  localparam int KIND_SPLIT   = 1;
  localparam int KIND_ANY     = 2;
  // Worst case for one access: two grants behind gaps, a full count, a slow response
  localparam int ACC_CYCLES   = 16;
  localparam int DRAIN_CYCLES = 8;
  localparam int TOTAL_CYCLES = (4 * N_ACC + 4) * ACC_CYCLES + 2 * 3 + 5 * DRAIN_CYCLES;
  localparam int LIMIT        = 4 * TOTAL_CYCLES;

  logic                clk;
  logic                rst_n;
  logic                valid_i;
  logic                ready_o;
  logic [31:0]         operand_a_i;
  logic [31:0]         operand_b_i;
  logic                we_i;
  lsu_pkg::lsu_size_e  size_i;
  logic                sext_i;
  logic [31:0]         wdata_i;
  logic                data_req_o;
  logic                data_gnt_i;
  logic [31:0]         data_addr_o;
  logic                data_we_o;
  logic [3:0]          data_be_o;
  logic [31:0]         data_wdata_o;
  logic                data_rvalid_i;
  logic [31:0]         data_rdata_i;
  logic                result_valid_o;
  logic [31:0]         rdata_o;
  logic                busy_o;
  logic                interruptible_o;
  logic                split_o;

  // Memory behaviour knobs
  logic                gnt_en;
  logic [1:0]          delay;
  logic                gnt_random;
  logic                slow;

  logic [31:0]         lfsr_q;
  logic [7:0]          golden [64];
  // Expected results in issue order, stores carry no check
  logic                exp_check [$];
  logic [31:0]         exp_val [$];
  int                  outst;
  int                  errs;
  int                  total_errs;
  int                  failed_tests;
  int                  test_no;
  int                  cycles = 0;

  lsu_top #(
    .DEPTH (DEPTH)
  ) dut_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .valid_i         (valid_i),
    .ready_o         (ready_o),
    .operand_a_i     (operand_a_i),
    .operand_b_i     (operand_b_i),
    .we_i            (we_i),
    .size_i          (size_i),
    .sext_i          (sext_i),
    .wdata_i         (wdata_i),
    .data_req_o      (data_req_o),
    .data_gnt_i      (data_gnt_i),
    .data_addr_o     (data_addr_o),
    .data_we_o       (data_we_o),
    .data_be_o       (data_be_o),
    .data_wdata_o    (data_wdata_o),
    .data_rvalid_i   (data_rvalid_i),
    .data_rdata_i    (data_rdata_i),
    .result_valid_o  (result_valid_o),
    .rdata_o         (rdata_o),
    .busy_o          (busy_o),
    .interruptible_o (interruptible_o),
    .split_o         (split_o)
  );

  tb_lsu_mem mem_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .gnt_en_i (gnt_en),
    .delay_i  (delay),
    .req_i    (data_req_o),
    .gnt_o    (data_gnt_i),
    .addr_i   (data_addr_o),
    .we_i     (data_we_o),
    .be_i     (data_be_o),
    .wdata_i  (data_wdata_o),
    .rvalid_o (data_rvalid_i),
    .rdata_o  (data_rdata_i)
  );

  always #5 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////
  // Random numbers
  //////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  function automatic logic [7:0] fill_byte(input int j);
    fill_byte = 8'(j * 29 + 75);
  endfunction

  // Byte-wide mask of the lanes a byte enable pattern selects
  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    for (int b = 0; b < 4; b++) begin
      lane_mask[8*b +: 8] = {8{be[b]}};
    end
  endfunction

  //////////////////////////////
  // Cycle step and monitors
  //////////////////////////////

  // Samples outputs right at the edge, then drives the memory knobs
  task automatic next_cycle();
    logic [31:0] r;
    logic        chk;
    logic [31:0] v;
    @(posedge clk);
    if (result_valid_o) begin
      assert (exp_val.size() != 0) else begin
        $display("result_valid_o came with no access waiting for a result");
        errs++;
      end
      if (exp_val.size() != 0) begin
        chk = exp_check.pop_front();
        v   = exp_val.pop_front();
        if (chk) begin
          assert (rdata_o == v) else begin
            $display("FAILED rdata_o: got 0x%h, expected 0x%h", rdata_o, v);
            errs++;
          end
        end
      end
    end
    if (outst != 0) begin
      assert (!interruptible_o) else begin
        $display("FAILED interruptible_o: got 0x%h, expected 0x0", interruptible_o);
        errs++;
      end
      assert (busy_o) else begin
        $display("FAILED busy_o: got 0x%h, expected 0x1", busy_o);
        errs++;
      end
    end
    outst = outst + int'(data_req_o && data_gnt_i) - int'(data_rvalid_i);
    assert (outst >= 0 && outst <= DEPTH) else begin
      $display("Outstanding transfers out of range, now %0d", outst);
      errs++;
    end
    rand_bits(1, r);
    gnt_en <= !gnt_random || r[0];
    rand_bits(2, r);
    delay  <= slow ? 2'd3 : ((r[1:0] == 2'd0) ? 2'd1 : r[1:0]);
  endtask

  task automatic pause(input int n);
    valid_i <= 1'b0;
    repeat (n) next_cycle();
  endtask

  task automatic apply_reset();
    rst_n   <= 1'b0;
    valid_i <= 1'b0;
    repeat (3) next_cycle();
    rst_n   <= 1'b1;
    outst   = 0;
  endtask

  // Waits until every transfer has answered and every result was seen
  task automatic wait_drain();
    valid_i <= 1'b0;
    while (outst != 0 || exp_val.size() != 0) begin
      next_cycle();
    end
  endtask

  task automatic end_test(input string name);
    if (errs == 0) begin
      $display("test %0d %s: ok", test_no, name);
    end else begin
      $display("test %0d %s: %0d errors", test_no, name, errs);
      failed_tests++;
    end
    total_errs += errs;
    errs = 0;
    test_no++;
  endtask

  //////////////////////////////
  // Access generation
  //////////////////////////////

  task automatic pick_access(input int kind, input logic force_we, input logic we_val,
                             output logic we, output lsu_pkg::lsu_size_e size,
                             output logic sext, output logic [31:0] addr,
                             output logic [31:0] wdata);
    logic [31:0] r;
    rand_bits(1, r);
    we = force_we ? we_val : r[0];
    rand_bits(1, r);
    sext = r[0];
    rand_bits(32, wdata);
    rand_bits(32, addr);
    rand_bits(2, r);
    case (r[1:0])
      2'd0:    size = lsu_pkg::SIZE_BYTE;
      2'd1:    size = lsu_pkg::SIZE_HALF;
      default: size = lsu_pkg::SIZE_WORD;
    endcase
    if (kind == KIND_ALIGNED) begin
      if (size == lsu_pkg::SIZE_HALF) addr[0] = 1'b0;
      if (size == lsu_pkg::SIZE_WORD) addr[1:0] = 2'b00;
    end else if (kind == KIND_SPLIT) begin
      // Halfword in the top lane or a word off its boundary
      if (r[0]) begin
        size      = lsu_pkg::SIZE_HALF;
        addr[1:0] = 2'b11;
      end else begin
        size = lsu_pkg::SIZE_WORD;
        if (addr[1:0] == 2'b00) addr[1:0] = 2'b01;
      end
    end
  endtask

  // Issues one access, checks both address phases and queues its result
  task automatic run_access(input logic we, input lsu_pkg::lsu_size_e size, input logic sext,
                            input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] r;
    logic [31:0] exp_v;
    logic [31:0] next_addr;
    logic [31:0] hold_addr;
    logic [31:0] hold_wdata;
    logic [3:0]  hold_be;
    logic [7:0]  be_full;
    logic [63:0] wdata_full;
    logic [31:0] wmask;
    logic [31:0] exp_wd;
    logic        split;
    logic        held;
    logic        last_grant;
    logic        done;
    int          nb;
    int          idx;
    int          n_grants;
    int          want;
    nb    = (size == lsu_pkg::SIZE_BYTE) ? 1 : (size == lsu_pkg::SIZE_HALF) ? 2 : 4;
    split = (nb == 4 && addr[1:0] != 2'b00) || (nb == 2 && addr[1:0] == 2'b11);
    want  = split ? 2 : 1;
    next_addr = {addr[31:2], 2'b00} + 32'd4;
    // Golden model, little endian bytes from the access address up
    // Lanes of the first word low, lanes of the next word high
    exp_v      = '0;
    be_full    = '0;
    wdata_full = '0;
    for (int i = 0; i < nb; i++) begin
      idx = int'((addr + 32'(i)) & 32'd63);
      be_full[int'(addr[1:0]) + i]               = 1'b1;
      wdata_full[8 * (int'(addr[1:0]) + i) +: 8] = wdata[8*i +: 8];
      if (we) golden[idx] = wdata[8*i +: 8];
      else exp_v[8*i +: 8] = golden[idx];
    end
    if (!we && sext && nb < 4 && exp_v[8*nb-1]) begin
      exp_v = exp_v | ~((32'd1 << (8 * nb)) - 32'd1);
    end
    rand_bits(32, r);
    valid_i     <= 1'b1;
    operand_a_i <= r;
    operand_b_i <= addr - r;
    we_i        <= we;
    size_i      <= size;
    sext_i      <= sext;
    wdata_i     <= wdata;
    n_grants = 0;
    held     = 1'b0;
    done     = 1'b0;
    while (!done) begin
      next_cycle();
      // Payload stays put while the memory withholds its grant
      if (held) begin
        assert (data_req_o) else begin
          $display("data_req_o dropped before its grant");
          errs++;
        end
        assert (data_addr_o == hold_addr && data_be_o == hold_be && data_wdata_o == hold_wdata)
        else begin
          $display("FAILED data_addr_o/data_be_o/data_wdata_o: 0x%h/0x%h/0x%h, held 0x%h/0x%h/0x%h",
                   data_addr_o, data_be_o, data_wdata_o, hold_addr, hold_be, hold_wdata);
          errs++;
        end
      end
      held       = data_req_o && !data_gnt_i;
      hold_addr  = data_addr_o;
      hold_be    = data_be_o;
      hold_wdata = data_wdata_o;
      last_grant = 1'b0;
      if (data_req_o && data_gnt_i) begin
        n_grants++;
        if (n_grants == 1) begin
          assert (data_addr_o == addr) else begin
            $display("FAILED data_addr_o: got 0x%h, expected 0x%h", data_addr_o, addr);
            errs++;
          end
          assert (data_be_o == be_full[3:0]) else begin
            $display("FAILED data_be_o: got 0x%h, expected 0x%h", data_be_o, be_full[3:0]);
            errs++;
          end
          assert (split_o == split) else begin
            $display("FAILED split_o: got 0x%h, expected 0x%h", split_o, split);
            errs++;
          end
        end else begin
          assert (data_addr_o == next_addr) else begin
            $display("FAILED data_addr_o: got 0x%h, expected 0x%h", data_addr_o, next_addr);
            errs++;
          end
          assert (data_be_o == be_full[7:4]) else begin
            $display("FAILED data_be_o: got 0x%h, expected 0x%h", data_be_o, be_full[7:4]);
            errs++;
          end
        end
        assert (data_we_o == we) else begin
          $display("FAILED data_we_o: got 0x%h, expected 0x%h", data_we_o, we);
          errs++;
        end
        // Store bytes must sit in their enabled lanes
        if (we) begin
          wmask  = lane_mask((n_grants == 1) ? be_full[3:0] : be_full[7:4]);
          exp_wd = (n_grants == 1) ? wdata_full[31:0] : wdata_full[63:32];
          assert ((data_wdata_o & wmask) == exp_wd) else begin
            $display("FAILED data_wdata_o: got 0x%h, expected 0x%h",
                     data_wdata_o & wmask, exp_wd);
            errs++;
          end
        end
        last_grant = (n_grants == want);
      end
      if (ready_o) begin
        assert (last_grant) else begin
          $display("ready_o rose before the last grant of the access");
          errs++;
        end
        done = 1'b1;
      end
    end
    assert (n_grants == want) else begin
      $display("FAILED grant count: got 0x%h, expected 0x%h", n_grants, want);
      errs++;
    end
    exp_check.push_back(!we);
    exp_val.push_back(exp_v);
  endtask

  // Draws and runs n accesses, gap of idle cycles after each
  task automatic run_batch(input int n, input int kind, input int gap);
    logic               we;
    lsu_pkg::lsu_size_e size;
    logic               sext;
    logic [31:0]        addr;
    logic [31:0]        wdata;
    for (int i = 0; i < n; i++) begin
      pick_access(kind, 1'b0, 1'b0, we, size, sext, addr, wdata);
      run_access(we, size, sext, addr, wdata);
      if (gap != 0) pause(gap);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic               we;
    lsu_pkg::lsu_size_e size;
    logic               sext;
    logic [31:0]        addr;
    logic [31:0]        wdata;
    clk          = 1'b0;
    rst_n        = 1'b0;
    valid_i      = 1'b0;
    operand_a_i  = '0;
    operand_b_i  = '0;
    we_i         = 1'b0;
    size_i       = lsu_pkg::SIZE_BYTE;
    sext_i       = 1'b0;
    wdata_i      = '0;
    gnt_en       = 1'b1;
    delay        = 2'd1;
    gnt_random   = 1'b0;
    slow         = 1'b0;
    lfsr_q       = 32'hbde4_d064;
    outst        = 0;
    errs         = 0;
    total_errs   = 0;
    failed_tests = 0;
    test_no      = 1;
    for (int j = 0; j < 64; j++) begin
      golden[j] = fill_byte(j);
    end
    apply_reset();

    // Stores first, then loads over the same small memory
    for (int i = 0; i < N_ACC; i++) begin
      pick_access(KIND_ALIGNED, 1'b1, (i < N_ACC / 2), we, size, sext, addr, wdata);
      run_access(we, size, sext, addr, wdata);
      pause(1);
    end
    wait_drain();
    end_test("aligned stores and loads");

    run_batch(N_ACC, KIND_SPLIT, 2);
    wait_drain();
    end_test("split accesses");

    gnt_random = 1'b1;
    run_batch(N_ACC, KIND_ANY, 0);
    wait_drain();
    gnt_random = 1'b0;
    end_test("grant gaps");

    slow = 1'b1;
    run_batch(N_ACC, KIND_ANY, 0);
    wait_drain();
    slow = 1'b0;
    end_test("back-to-back with slow responses");

    // Status right after a fresh reset, then after a short burst drains
    apply_reset();
    next_cycle();
    assert (!busy_o && interruptible_o && !data_req_o && !split_o && !result_valid_o)
    else begin
      $display("Status outputs wrong after reset, busy_o=%0b interruptible_o=%0b",
               busy_o, interruptible_o);
      errs++;
    end
    slow = 1'b1;
    run_batch(4, KIND_ANY, 0);
    wait_drain();
    next_cycle();
    assert (!busy_o) else begin
      $display("FAILED busy_o: got 0x%h, expected 0x0", busy_o);
      errs++;
    end
    assert (interruptible_o) else begin
      $display("FAILED interruptible_o: got 0x%h, expected 0x1", interruptible_o);
      errs++;
    end
    slow = 1'b0;
    end_test("status outputs");

    $display("%0d tests run, %0d failed, %0d errors in total",
             test_no - 1, failed_tests, total_errs);
    if (total_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/tb_lsu_mem.sv ====
/*
 * Behavioural OBI data memory for the load-store unit testbench
 * Random grant, in-order responses after 1 to 3 cycles, byte-enabled stores
 */

`default_nettype none

module tb_lsu_mem (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        gnt_en_i,
  input  wire logic [1:0]  delay_i,
  input  wire logic        req_i,
  output logic             gnt_o,
  input  wire logic [31:0] addr_i,
  input  wire logic        we_i,
  input  wire logic [3:0]  be_i,
  input  wire logic [31:0] wdata_i,
  output logic             rvalid_o,
  output logic [31:0]      rdata_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WORDS = 16;

  logic [31:0] mem [WORDS];
  // Granted transfers waiting for their response, oldest first
  logic [31:0] rsp_data [$];
  int          rsp_due [$];
  logic [31:0] rsp_word;
  int          cyc;
  int          idx;

  // Every byte gets a value derived from its full byte address
  initial begin
    for (int w = 0; w < WORDS; w++) begin
      for (int b = 0; b < 4; b++) begin
        mem[w][8*b +: 8] = 8'((4 * w + b) * 29 + 75);
      end
    end
  end

  assign gnt_o = req_i && gnt_en_i;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc      <= 0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      rsp_data.delete();
      rsp_due.delete();
    end else begin
      cyc <= cyc + 1;
      // Stores land at the grant, loads read the word at the grant
      if (req_i && gnt_o) begin
        idx = int'(addr_i[5:2]);
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (be_i[b]) begin
              mem[idx][8*b +: 8] = wdata_i[8*b +: 8];
            end
          end
        end
        rsp_data.push_back(mem[idx]);
        rsp_due.push_back(cyc + int'(delay_i) - 1);
      end
      // At most one response per cycle, strictly in grant order
      rvalid_o <= 1'b0;
      if (rsp_due.size() != 0 && rsp_due[0] <= cyc) begin
        rsp_word = rsp_data.pop_front();
        void'(rsp_due.pop_front());
        rvalid_o <= 1'b1;
        rdata_o  <= rsp_word;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/lsu_top.sv ====
/*
 * Load-store unit top level
 * Request builder, transaction tracker and read aligner on an OBI data port
 */

`default_nettype none

module lsu_top #(
  parameter int unsigned DEPTH = lsu_pkg::LSU_DEPTH_DEFAULT
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,

  // Execute stage
  input  wire logic                       valid_i,
  output logic                            ready_o,
  input  wire logic [lsu_pkg::XLEN-1:0]   operand_a_i,
  input  wire logic [lsu_pkg::XLEN-1:0]   operand_b_i,
  input  wire logic                       we_i,
  input  wire lsu_pkg::lsu_size_e         size_i,
  input  wire logic                       sext_i,
  input  wire logic [lsu_pkg::XLEN-1:0]   wdata_i,

  // OBI data port
  output logic                            data_req_o,
  input  wire logic                       data_gnt_i,
  output logic [lsu_pkg::XLEN-1:0]        data_addr_o,
  output logic                            data_we_o,
  output logic [lsu_pkg::BE_W-1:0]        data_be_o,
  output logic [lsu_pkg::XLEN-1:0]        data_wdata_o,
  input  wire logic                       data_rvalid_i,
  input  wire logic [lsu_pkg::XLEN-1:0]   data_rdata_i,

  // Write-back result
  output logic                            result_valid_o,
  output logic [lsu_pkg::XLEN-1:0]        rdata_o,

  // Status
  output logic                            busy_o,
  output logic                            interruptible_o,
  output logic                            split_o
);

  lsu_req_if         req_if ();
  lsu_pkg::lsu_tag_t head_tag;

  lsu_request u_request (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     (valid_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .we_i        (we_i),
    .size_i      (size_i),
    .sext_i      (sext_i),
    .wdata_i     (wdata_i),
    .split_o     (split_o),
    .req         (req_if.builder)
  );

  lsu_txn_tracker #(
    .DEPTH (DEPTH)
  ) u_txn_tracker (
    .clk             (clk),
    .rst_n           (rst_n),
    .valid_i         (valid_i),
    .req             (req_if.tracker),
    .data_req_o      (data_req_o),
    .data_gnt_i      (data_gnt_i),
    .data_addr_o     (data_addr_o),
    .data_we_o       (data_we_o),
    .data_be_o       (data_be_o),
    .data_wdata_o    (data_wdata_o),
    .data_rvalid_i   (data_rvalid_i),
    .head_tag_o      (head_tag),
    .ready_o         (ready_o),
    .busy_o          (busy_o),
    .interruptible_o (interruptible_o)
  );

  // Every response goes straight to the aligner
  lsu_rdata_align u_rdata_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .head_tag_i     (head_tag),
    .result_valid_o (result_valid_o),
    .rdata_o        (rdata_o)
  );

endmodule

`default_nettype wire

// ==== lsu/lsu_rdata_align.sv ====
/*
 * Read-data path of the load-store unit
 * Split merge, realignment and zero or sign extension
 */

`default_nettype none

module lsu_rdata_align (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       data_rvalid_i,
  input  wire logic [lsu_pkg::XLEN-1:0]   data_rdata_i,
  input  wire lsu_pkg::lsu_tag_t          head_tag_i,
  output logic                            result_valid_o,
  output logic [lsu_pkg::XLEN-1:0]        rdata_o
);

  // Raw word of the first half
  logic [lsu_pkg::XLEN-1:0]   rdata_q;
  logic                       is_split;
  logic [2*lsu_pkg::XLEN-1:0] rdata_full;
  logic [2*lsu_pkg::XLEN-1:0] rdata_shift;
  logic [lsu_pkg::XLEN-1:0]   rdata_aligned;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (data_rvalid_i && !head_tag_i.we && head_tag_i.split_first) begin
      rdata_q <= data_rdata_i;
    end
  end

  //////////////////////////////
  // Merge and realign
  //////////////////////////////

  // Same rule the builder used to split the access
  assign is_split = ((head_tag_i.size == lsu_pkg::SIZE_WORD) && (head_tag_i.offset != 2'b00))
                 || ((head_tag_i.size == lsu_pkg::SIZE_HALF) && (head_tag_i.offset == 2'b11));

  // New word on top, previous word or a copy below
  assign rdata_full    = is_split ? {data_rdata_i, rdata_q} : {data_rdata_i, data_rdata_i};
  assign rdata_shift   = rdata_full >> {head_tag_i.offset, 3'b000};
  assign rdata_aligned = rdata_shift[lsu_pkg::XLEN-1:0];

  //////////////////////////////
  // Extension
  //////////////////////////////

  always_comb begin
    case (head_tag_i.size)
      lsu_pkg::SIZE_BYTE: begin
        rdata_o = {{(lsu_pkg::XLEN-8){head_tag_i.sext && rdata_aligned[7]}},
                   rdata_aligned[7:0]};
      end
      lsu_pkg::SIZE_HALF: begin
        rdata_o = {{(lsu_pkg::XLEN-16){head_tag_i.sext && rdata_aligned[15]}},
                   rdata_aligned[15:0]};
      end
      default: begin
        rdata_o = rdata_aligned;
      end
    endcase
  end

  // First half of a split gives no result, stores return don't-care data
  assign result_valid_o = data_rvalid_i && head_tag_i.last;

endmodule

`default_nettype wire

// ==== lsu/lsu_txn_tracker.sv ====
/*
 * Transaction tracker of the load-store unit
 * Outstanding-transfer count, OBI request gating,
 * in-order tag queue, core-side ready and status
 */

`default_nettype none

module lsu_txn_tracker #(
  parameter int unsigned DEPTH = lsu_pkg::LSU_DEPTH_DEFAULT
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       valid_i,
  lsu_req_if.tracker                      req,
  output logic                            data_req_o,
  input  wire logic                       data_gnt_i,
  output logic [lsu_pkg::XLEN-1:0]        data_addr_o,
  output logic                            data_we_o,
  output logic [lsu_pkg::BE_W-1:0]        data_be_o,
  output logic [lsu_pkg::XLEN-1:0]        data_wdata_o,
  input  wire logic                       data_rvalid_i,
  output lsu_pkg::lsu_tag_t               head_tag_o,
  output logic                            ready_o,
  output logic                            busy_o,
  output logic                            interruptible_o
);

  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [CNT_W-1:0]  cnt_q;
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  // Request seen last cycle without a grant
  logic              pend_q;
  lsu_pkg::lsu_tag_t tag_q [DEPTH];

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////
  // OBI address phase
  //////////////////////////////

  // No new request once DEPTH transfers wait for rvalid
  assign data_req_o   = req.valid && (cnt_q < CNT_W'(DEPTH));
  assign req.accept   = data_req_o && data_gnt_i;

  assign data_addr_o  = req.addr;
  assign data_we_o    = req.we;
  assign data_be_o    = req.be;
  assign data_wdata_o = req.wdata;

  // Count up on grant, down on response, both may coincide
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      case ({req.accept, data_rvalid_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  //////////////////////////////
  // Tag queue
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (req.accept) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (data_rvalid_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
    end
  end

  // Count gating keeps a push off a slot still waiting
  always_ff @(posedge clk) begin
    if (req.accept) begin
      tag_q[wr_ptr_q] <= req.tag;
    end
  end

  // Oldest transfer, matches the next rvalid
  assign head_tag_o = tag_q[rd_ptr_q];

  //////////////////////////////
  // Core side and status
  //////////////////////////////

  assign ready_o = !valid_i || (req.accept && req.tag.last);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= req.valid && !req.accept;
    end
  end

  assign busy_o          = (cnt_q != '0) || req.valid;
  // A request held over a cycle must not be withdrawn
  assign interruptible_o = !pend_q && (cnt_q == '0);

endmodule

`default_nettype wire

// ==== lsu/lsu_request.sv ====
/*
 * Request builder of the load-store unit
 * Address sum, split detection and split state,
 * byte enables, write-data rotation and transfer tag
 */

`default_nettype none

module lsu_request (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       valid_i,
  input  wire logic [lsu_pkg::XLEN-1:0]   operand_a_i,
  input  wire logic [lsu_pkg::XLEN-1:0]   operand_b_i,
  input  wire logic                       we_i,
  input  wire lsu_pkg::lsu_size_e         size_i,
  input  wire logic                       sext_i,
  input  wire logic [lsu_pkg::XLEN-1:0]   wdata_i,
  output logic                            split_o,
  lsu_req_if.builder                      req
);

  logic [lsu_pkg::XLEN-1:0]   addr;
  logic [1:0]                 offset;
  logic                       needs_split;
  // Second address phase of a split access in progress
  logic                       split_q;
  logic [lsu_pkg::BE_W-1:0]   size_mask;
  logic [2*lsu_pkg::BE_W-1:0] be_wide;
  logic [2*lsu_pkg::XLEN-1:0] wdata_wide;

  //////////////////////////////
  // Address and split check
  //////////////////////////////

  assign addr   = operand_a_i + operand_b_i;
  assign offset = addr[1:0];

  // Word off its boundary, or halfword in the top byte lane
  always_comb begin
    needs_split = 1'b0;
    case (size_i)
      lsu_pkg::SIZE_WORD: needs_split = (offset != 2'b00);
      lsu_pkg::SIZE_HALF: needs_split = (offset == 2'b11);
      default:            needs_split = 1'b0;
    endcase
  end

  // High during the first half only
  assign split_o = valid_i && needs_split && !split_q;

  // Set on the first accept, cleared on the second
  // Also cleared when EX drops the access
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_i) begin
      split_q <= 1'b0;
    end else if (req.accept) begin
      split_q <= split_o;
    end
  end

  //////////////////////////////
  // Byte enables and data
  //////////////////////////////

  always_comb begin
    case (size_i)
      lsu_pkg::SIZE_BYTE: size_mask = 4'b0001;
      lsu_pkg::SIZE_HALF: size_mask = 4'b0011;
      default:            size_mask = 4'b1111;
    endcase
  end

  // Shift across two words, upper word holds the lanes of the second half
  assign be_wide = {{lsu_pkg::BE_W{1'b0}}, size_mask} << offset;

  // Rotate left so byte 0 lands in the lane of the offset
  // Second half reuses the same rotation, its low lanes carry the top bytes
  assign wdata_wide = {wdata_i, wdata_i} << {offset, 3'b000};

  //////////////////////////////
  // Request to the tracker
  //////////////////////////////

  assign req.valid = valid_i;
  assign req.we    = we_i;
  assign req.be    = split_q ? be_wide[2*lsu_pkg::BE_W-1:lsu_pkg::BE_W]
                             : be_wide[lsu_pkg::BE_W-1:0];
  assign req.wdata = wdata_wide[2*lsu_pkg::XLEN-1:lsu_pkg::XLEN];

  // Second half goes to the next word, aligned
  assign req.addr  = split_q ? ({addr[lsu_pkg::XLEN-1:2], 2'b00} + lsu_pkg::XLEN'(4))
                             : addr;

  always_comb begin
    req.tag.size        = size_i;
    req.tag.sext        = sext_i;
    req.tag.we          = we_i;
    req.tag.offset      = offset;
    req.tag.split_first = split_o;
    // Only the first half of a split is not last
    req.tag.last        = !split_o;
  end

endmodule

`default_nettype wire

// ==== common/lsu_req_if.sv ====
/*
 * Bus request from the request builder to the transaction tracker
 */

`default_nettype none

interface lsu_req_if;

  // Handshake, valid is held with its payload until accept
  logic                            valid;
  logic                            accept;

  // Payload of one bus transfer
  logic [lsu_pkg::XLEN-1:0]        addr;
  logic                            we;
  logic [lsu_pkg::BE_W-1:0]        be;
  logic [lsu_pkg::XLEN-1:0]        wdata;
  lsu_pkg::lsu_tag_t               tag;

  modport builder (
    output valid, addr, we, be, wdata, tag,
    input  accept
  );

  modport tracker (
    input  valid, addr, we, be, wdata, tag,
    output accept
  );

endinterface

`default_nettype wire

// ==== common/lsu_pkg.sv ====
/*
 * Shared definitions for the load-store unit
 * Access size enum, outstanding-transfer tag and data path constants
 */

`default_nettype none

package lsu_pkg;

  // Data and address width
  localparam int unsigned XLEN = 32;

  // One byte enable per byte lane
  localparam int unsigned BE_W = XLEN / 8;

  // Outstanding transfers allowed on the bus by default
  localparam int unsigned LSU_DEPTH_DEFAULT = 2;

  // Access size, encoded as in the funct3 field of loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  //////////////////////////////
  // Tag of one bus transfer
  //////////////////////////////

  // Travels from the address phase to the response, 8 bits wide
  typedef struct packed {
    lsu_size_e  size;
    logic       sext;
    logic       we;
    // Low address bits of the original access
    logic [1:0] offset;
    // First half of a split access
    logic       split_first;
    // Final transfer of the access, qualifies the result
    logic       last;
  } lsu_tag_t;

endpackage

`default_nettype wire
